// ==== logic/noc_pkg.sv ====
// flit field widths, flit and vc typedefs, buffer localparams and vc index helpers
`default_nettype none

package noc_pkg;

    localparam int V      = 4;                 // virtual channels
    localparam int B      = 4;                 // flits per vc, head reg included
    localparam int FPAY   = 32;                // payload width
    localparam int CLS_W  = 2;                 // class field
    localparam int DST_W  = 4;                 // destination port field
    localparam int VC_W   = 2;                 // binary vc index
    localparam int FLIT_W = 2 + V + FPAY;      // head, tail, vc, payload

    localparam int HEAD_BIT = FLIT_W - 1;      // head flag, tail sits just below
    localparam int VC_LSB   = FPAY;            // one-hot vc field above payload
    localparam int CLS_LSB  = 0;               // class in low payload bits
    localparam int DST_LSB  = CLS_W;           // destination right after class

    localparam int SLOTS     = B - 1;          // memory slots per vc
    localparam int MEM_DEPTH = V * SLOTS;      // shared memory size
    localparam int MEM_AW    = $clog2(MEM_DEPTH);
    localparam int SLOT_W    = $clog2(SLOTS);
    localparam int CNT_W     = $clog2(B);      // holds 0..SLOTS
    localparam int OQ_DEPTH  = 2;              // output queue entries

    typedef logic [FLIT_W-1:0] flit_t;
    typedef logic [FPAY-1:0]   payload_t;
    typedef logic [V-1:0]      vc_onehot_t;
    typedef logic [VC_W-1:0]   vc_bin_t;
    typedef logic [CLS_W-1:0]  class_t;
    typedef logic [DST_W-1:0]  dest_t;
    typedef logic [SLOT_W-1:0] slot_t;
    typedef logic [CNT_W-1:0]  cnt_t;
    typedef logic [MEM_AW-1:0] mem_addr_t;

    // one-hot vc to index, or of set positions
    function automatic vc_bin_t onehot_to_bin(input vc_onehot_t oh);
        vc_bin_t b;
        b = '0;
        for (int i = 0; i < V; i++) begin
            if (oh[i]) b = b | vc_bin_t'(i);
        end
        return b;
    endfunction

    function automatic vc_onehot_t vc_onehot(input vc_bin_t b);
        return vc_onehot_t'(1) << b;
    endfunction

endpackage

`default_nettype wire

// ==== logic/vc_flit_fifo.sv ====
// per-vc circular flit buffer in one shared memory with registered read data
`timescale 1ns/100ps
`default_nettype none

module vc_flit_fifo import noc_pkg::*; (
    input  wire         clk,
    input  wire         reset,

    input  wire         wr_en_i,        // one write per cycle
    input  wire vc_onehot_t wr_vc_i,
    input  wire flit_t  wr_flit_i,

    input  wire         rd_en_i,        // pop oldest flit of rd_vc_i
    input  wire vc_onehot_t rd_vc_i,

    output flit_t       rd_flit_o,      // valid one cycle after rd_en_i
    output vc_onehot_t  not_empty_o
);

    flit_t      mem [MEM_DEPTH];        // V regions of SLOTS flits
    slot_t      wr_ptr [V];
    slot_t      rd_ptr [V];
    cnt_t       cnt [V];                // flits held per vc

    vc_onehot_t wr_hit;                 // qualified write strobe
    vc_onehot_t rd_hit;                 // qualified read strobe
    vc_bin_t    wr_bin;
    vc_bin_t    rd_bin;
    mem_addr_t  wr_addr;
    mem_addr_t  rd_addr;

    // wrap inside the region of one vc
    function automatic slot_t next_slot(input slot_t p);
        return (p == slot_t'(SLOTS - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wr_hit = wr_en_i ? wr_vc_i : '0;
    assign rd_hit = rd_en_i ? rd_vc_i : '0;

    assign wr_bin = onehot_to_bin(wr_vc_i);
    assign rd_bin = onehot_to_bin(rd_vc_i);

    // region base plus slot offset
    assign wr_addr = mem_addr_t'(SLOTS * wr_bin + wr_ptr[wr_bin]);
    assign rd_addr = mem_addr_t'(SLOTS * rd_bin + rd_ptr[rd_bin]);

    // storage and registered read port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr] <= wr_flit_i;
        end
        if (rd_en_i) begin
            rd_flit_o <= mem[rd_addr];      // one cycle read latency
        end
    end

    // pointers and occupancy per vc
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < V; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                cnt[i]    <= '0;
            end
        end else begin
            for (int i = 0; i < V; i++) begin
                if (wr_hit[i]) begin
                    wr_ptr[i] <= next_slot(wr_ptr[i]);
                end
                if (rd_hit[i]) begin
                    rd_ptr[i] <= next_slot(rd_ptr[i]);
                end
                if (wr_hit[i] && !rd_hit[i]) begin
                    cnt[i] <= cnt[i] + 1'b1;    // push only
                end else if (rd_hit[i] && !wr_hit[i]) begin
                    cnt[i] <= cnt[i] - 1'b1;    // pop only
                end
            end
        end
    end

    // flags straight from the counters
    always_comb begin
        for (int i = 0; i < V; i++) begin
            not_empty_o[i] = (cnt[i] != '0);
        end
    end

endmodule

`default_nettype wire

// ==== logic/head_flit_reg_buffer.sv ====
// per-vc head flit registers with bypass, header class/destination capture and flit fifo
`timescale 1ns/100ps
`default_nettype none

module head_flit_reg_buffer import noc_pkg::*; (
    input  wire         clk,
    input  wire         reset,

    input  wire         wr_en_i,
    input  wire vc_onehot_t wr_vc_i,
    input  wire flit_t  wr_flit_i,

    input  wire         rd_en_i,        // consume head of rd_vc_i
    input  wire vc_onehot_t rd_vc_i,

    output flit_t       head_flit_o,    // cycle after the read
    output class_t      head_class_o,
    output dest_t       head_dest_o,
    output vc_onehot_t  vc_not_empty_o
);

    vc_onehot_t wr_req;                 // write strobe per vc
    vc_onehot_t rd_req;                 // read strobe per vc
    vc_onehot_t valid;                  // head reg holds a flit
    vc_onehot_t fifo_ne;
    vc_onehot_t bypass;                 // write lands in head reg
    vc_onehot_t fifo_rd;                // refill head from fifo
    vc_onehot_t bypass_d;
    vc_onehot_t fifo_rd_d;
    vc_onehot_t load_en;                // head reg written this edge

    logic       fifo_wr_en;
    logic       fifo_rd_en;
    flit_t      fifo_flit;
    flit_t      din_d;                  // bypassed flit, one cycle late

    flit_t      head_reg [V];
    class_t     class_reg [V];
    dest_t      dest_reg [V];
    flit_t      load_flit [V];

    vc_bin_t    rd_bin_d;               // read vc of last cycle
    flit_t      head_sel;

    assign wr_req = wr_en_i ? wr_vc_i : '0;
    assign rd_req = rd_en_i ? rd_vc_i : '0;

    // empty vc, or head leaving with nothing behind it
    assign bypass = wr_req & (~valid | (rd_req & ~fifo_ne));

    assign fifo_wr_en = wr_en_i & ~(|bypass);
    assign fifo_rd    = rd_req & fifo_ne;
    assign fifo_rd_en = |fifo_rd;

    vc_flit_fifo u_fifo (
        .clk         (clk),
        .reset       (reset),
        .wr_en_i     (fifo_wr_en),
        .wr_vc_i     (wr_vc_i),
        .wr_flit_i   (wr_flit_i),
        .rd_en_i     (fifo_rd_en),
        .rd_vc_i     (rd_vc_i),
        .rd_flit_o   (fifo_flit),
        .not_empty_o (fifo_ne)
    );

    // head reg loads one edge late so a read this cycle still sees the old head
    assign load_en = bypass_d | fifo_rd_d;

    always_comb begin
        for (int i = 0; i < V; i++) begin
            load_flit[i] = bypass_d[i] ? din_d : fifo_flit;   // never both per vc
        end
    end

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            valid     <= '0;
            bypass_d  <= '0;
            fifo_rd_d <= '0;
            rd_bin_d  <= '0;
        end else begin
            bypass_d  <= bypass;
            fifo_rd_d <= fifo_rd;
            if (rd_en_i) begin
                rd_bin_d <= onehot_to_bin(rd_vc_i);
            end
            for (int i = 0; i < V; i++) begin
                if (bypass[i]) begin
                    valid[i] <= 1'b1;
                end else if (rd_req[i] && !fifo_ne[i]) begin
                    valid[i] <= 1'b0;           // last flit of vc gone
                end
            end
        end
    end

    // flit payload and header info
    always_ff @(posedge clk) begin
        din_d <= wr_flit_i;
        for (int i = 0; i < V; i++) begin
            if (load_en[i]) begin
                head_reg[i] <= load_flit[i];
                if (load_flit[i][HEAD_BIT]) begin
                    class_reg[i] <= load_flit[i][CLS_LSB +: CLS_W];
                    dest_reg[i]  <= load_flit[i][DST_LSB +: DST_W];
                end
            end
        end
    end

    assign vc_not_empty_o = valid;

    // output mux on the delayed read vc
    assign head_sel = head_reg[rd_bin_d];

    always_comb begin
        head_flit_o                 = head_sel;
        head_flit_o[VC_LSB +: V]    = vc_onehot(rd_bin_d);  // vc that held it
    end

    assign head_class_o = class_reg[rd_bin_d];
    assign head_dest_o  = dest_reg[rd_bin_d];

endmodule

`default_nettype wire

// ==== logic/vc_output_stage.sv ====
// round-robin vc read arbiter, credit return and two-entry output queue
`timescale 1ns/100ps
`default_nettype none

module vc_output_stage import noc_pkg::*; (
    input  wire         clk,
    input  wire         reset,

    input  wire vc_onehot_t vc_not_empty_i,
    input  wire flit_t  head_flit_i,    // data of last cycle's read
    input  wire class_t head_class_i,
    input  wire dest_t  head_dest_i,

    output logic        rd_en_o,
    output vc_onehot_t  rd_vc_o,
    output vc_onehot_t  credit_o,       // one per read issued

    output logic        out_valid_o,
    input  wire         out_ready_i,
    output flit_t       out_flit_o,
    output vc_bin_t     out_vc_o,
    output class_t      out_class_o,
    output dest_t       out_dest_o
);

    // queue entries plus read in flight
    typedef enum logic [1:0] {ARB_IDLE, ARB_ISSUE, ARB_FULL} arb_state_e;

    arb_state_e state, state_nxt;
    vc_bin_t    rr_ptr;                 // last granted vc
    vc_onehot_t last_rd;                // head reg of this vc still refilling
    vc_onehot_t req;
    vc_bin_t    grant_bin;
    logic       grant_found;
    logic       can_issue;
    logic       pop;
    logic       inflight;               // head data arrives this cycle
    vc_bin_t    inflight_vc;

    flit_t      q_flit [OQ_DEPTH];
    vc_bin_t    q_vc [OQ_DEPTH];
    class_t     q_cls [OQ_DEPTH];
    dest_t      q_dst [OQ_DEPTH];
    logic       q_wr;
    logic       q_rd;
    logic [1:0] q_cnt;

    assign req = vc_not_empty_i & ~last_rd;
    assign pop = out_valid_o & out_ready_i;

    // first requester after rr_ptr, wraps around
    always_comb begin
        grant_bin   = rr_ptr;
        grant_found = 1'b0;
        for (int k = 1; k <= V; k++) begin
            if (!grant_found && req[vc_bin_t'(rr_ptr + k)]) begin
                grant_found = 1'b1;
                grant_bin   = vc_bin_t'(rr_ptr + k);
            end
        end
    end

    assign can_issue = (state != ARB_FULL) | pop;     // a pop frees a slot
    assign rd_en_o   = grant_found & can_issue;
    assign rd_vc_o   = rd_en_o ? vc_onehot(grant_bin) : '0;
    assign credit_o  = rd_vc_o;

    always_comb begin
        state_nxt = state;
        case (state)
            ARB_IDLE:  if (rd_en_o) state_nxt = ARB_ISSUE;
            ARB_ISSUE: begin
                if (rd_en_o && !pop) begin
                    state_nxt = ARB_FULL;
                end else if (!rd_en_o && pop) begin
                    state_nxt = ARB_IDLE;
                end
            end
            ARB_FULL:  if (!rd_en_o && pop) state_nxt = ARB_ISSUE;
            default:   state_nxt = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ARB_IDLE;
            rr_ptr      <= '0;
            last_rd     <= '0;
            inflight    <= 1'b0;
            inflight_vc <= '0;
            q_wr        <= 1'b0;
            q_rd        <= 1'b0;
            q_cnt       <= '0;
        end else begin
            state    <= state_nxt;
            last_rd  <= rd_vc_o;
            inflight <= rd_en_o;
            if (rd_en_o) begin
                rr_ptr      <= grant_bin;
                inflight_vc <= grant_bin;
            end
            if (inflight) q_wr <= ~q_wr;
            if (pop) q_rd <= ~q_rd;
            if (inflight && !pop) begin
                q_cnt <= q_cnt + 1'b1;
            end else if (pop && !inflight) begin
                q_cnt <= q_cnt - 1'b1;
            end
        end
    end

    // queue payload, push at end of data cycle
    always_ff @(posedge clk) begin
        if (inflight) begin
            q_flit[q_wr] <= head_flit_i;
            q_vc[q_wr]   <= inflight_vc;
            q_cls[q_wr]  <= head_class_i;
            q_dst[q_wr]  <= head_dest_i;
        end
    end

    assign out_valid_o = (q_cnt != '0);
    assign out_flit_o  = q_flit[q_rd];  // held until pop
    assign out_vc_o    = q_vc[q_rd];
    assign out_class_o = q_cls[q_rd];
    assign out_dest_o  = q_dst[q_rd];

endmodule

`default_nettype wire

// ==== logic/noc_input_port.sv ====
// router input port top with head flit buffer and vc output stage
`timescale 1ns/100ps
`default_nettype none

module noc_input_port import noc_pkg::*; (
    input  wire         clk,
    input  wire         reset,

    input  wire         wr_en_i,        // upstream link write
    input  wire vc_onehot_t wr_vc_i,
    input  wire flit_t  wr_flit_i,

    output vc_onehot_t  credit_o,       // back to upstream

    output logic        out_valid_o,
    input  wire         out_ready_i,
    output flit_t       out_flit_o,
    output vc_bin_t     out_vc_o,
    output class_t      out_class_o,
    output dest_t       out_dest_o
);

    logic       rd_en;
    vc_onehot_t rd_vc;
    flit_t      head_flit;
    class_t     head_class;
    dest_t      head_dest;
    vc_onehot_t vc_not_empty;

    head_flit_reg_buffer u_head_buf (
        .clk            (clk),
        .reset          (reset),
        .wr_en_i        (wr_en_i),
        .wr_vc_i        (wr_vc_i),
        .wr_flit_i      (wr_flit_i),
        .rd_en_i        (rd_en),
        .rd_vc_i        (rd_vc),
        .head_flit_o    (head_flit),
        .head_class_o   (head_class),
        .head_dest_o    (head_dest),
        .vc_not_empty_o (vc_not_empty)
    );

    vc_output_stage u_out_stage (
        .clk            (clk),
        .reset          (reset),
        .vc_not_empty_i (vc_not_empty),
        .head_flit_i    (head_flit),
        .head_class_i   (head_class),
        .head_dest_i    (head_dest),
        .rd_en_o        (rd_en),
        .rd_vc_o        (rd_vc),
        .credit_o       (credit_o),
        .out_valid_o    (out_valid_o),
        .out_ready_i    (out_ready_i),
        .out_flit_o     (out_flit_o),
        .out_vc_o       (out_vc_o),
        .out_class_o    (out_class_o),
        .out_dest_o     (out_dest_o)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
// testbench clock source, 40 ns period, with a 3 cycle synchronous reset
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;         // 40 ns period
    end

    initial begin
        reset_o = 1'b1;
        repeat (3) @(posedge clk_o);        // three reset edges
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb/noc_input_port_chk.sv ====
// concurrent checks on credit return, vc read spacing and output hold, bound to the port top
`timescale 1ns/100ps
`default_nettype none

module noc_input_port_chk import noc_pkg::*; (
    input wire              clk,
    input wire              reset,
    input wire vc_onehot_t  credit_i,
    input wire vc_onehot_t  rd_vc_i,        // internal read strobe of the top
    input wire              out_valid_i,
    input wire              out_ready_i,
    input wire flit_t       out_flit_i,
    input wire vc_bin_t     out_vc_i,
    input wire class_t      out_class_i,
    input wire dest_t       out_dest_i
);

    int fail_cnt = 0;                       // failed assertions so far

    credit_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(credit_i))
        else begin
            fail_cnt++;
            $error("credit returned on more than one vc");
        end

    // head register needs a cycle to refill
    read_spacing: assert property (@(posedge clk) disable iff (reset)
        (rd_vc_i & $past(rd_vc_i)) == '0)
        else begin
            fail_cnt++;
            $error("same vc read in two consecutive cycles");
        end

    hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_flit_i)
        && $stable(out_vc_i) && $stable(out_class_i) && $stable(out_dest_i))
        else begin
            fail_cnt++;
            $error("output changed while stalled");
        end

endmodule

bind noc_input_port noc_input_port_chk u_chk (
    .clk         (clk),
    .reset       (reset),
    .credit_i    (credit_o),
    .rd_vc_i     (rd_vc),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_flit_i  (out_flit_o),
    .out_vc_i    (out_vc_o),
    .out_class_i (out_class_o),
    .out_dest_i  (out_dest_o)
);

`default_nettype wire

// ==== tb/noc_input_port_tb.sv ====
// testbench with lfsr packet traffic, per-vc reference queues, credit and fairness checks
`timescale 1ns/100ps
`default_nettype none

module noc_input_port_tb import noc_pkg::*; ();

    localparam int NUM_PKTS = 80;
    localparam int WAIT_MAX = 300;              // cycles per wait loop
    localparam int EXP_W    = CLS_W + DST_W + FLIT_W;

    logic       clk;
    logic       reset;
    logic       wr_en;
    vc_onehot_t wr_vc;
    flit_t      wr_flit;
    logic       out_ready;
    vc_onehot_t credit;
    logic       out_valid;
    flit_t      out_flit;
    vc_bin_t    out_vc;
    class_t     out_class;
    dest_t      out_dest;

    logic [31:0]      lfsr;
    logic [EXP_W-1:0] exp_q [V][$];             // {class, dest, flit} per vc
    class_t           cur_cls [V];              // class of packet being written
    dest_t            cur_dst [V];
    int               credits [V];
    int               skip_cnt [V];             // other-vc transfers since own
    bit               fair_on [V];
    int               flits_written;
    int               credits_seen;
    bit               rand_ready;
    logic             reset_q;
    logic             stall_q;
    flit_t            prev_flit;
    vc_bin_t          prev_vc;
    class_t           prev_cls;
    dest_t            prev_dst;
    int data_err, hdr_err, credit_err, stall_err, reset_err, fair_err, timeout_err;

    tb_clk_gen u_clk (.clk_o(clk), .reset_o(reset));

    noc_input_port u_dut (
        .clk         (clk),
        .reset       (reset),
        .wr_en_i     (wr_en),
        .wr_vc_i     (wr_vc),
        .wr_flit_i   (wr_flit),
        .credit_o    (credit),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready),
        .out_flit_o  (out_flit),
        .out_vc_o    (out_vc),
        .out_class_o (out_class),
        .out_dest_o  (out_dest)
    );

    // fibonacci taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};          // one step per bit
        end
        return v;
    endfunction

    function automatic bit values_match(input string sig, input flit_t exp, input flit_t got);
        bit ok;
        ok = (got === exp);
        assert (ok) else $display("[FAIL] %0t %s exp=%0h got=%0h", $time, sig, exp, got);
        return ok;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int i = 0; i < V; i++) n += exp_q[i].size();
        return n;
    endfunction

    task automatic next_cycle();
        @(negedge clk);                         // all inputs change here
        if (rand_ready) out_ready = (take_bits(3) != 0);
    endtask

    task automatic send_flit(input vc_bin_t vc, input flit_t f, output bit ok);
        int    n;
        flit_t exp_f;
        ok = 1'b1;
        n  = 0;
        while (credits[vc] == 0) begin          // stall until a credit comes back
            wr_en = 1'b0;
            next_cycle();
            n++;
            if (n > WAIT_MAX) begin
                $display("error: no credit returned for vc %0d within %0d cycles", vc, n);
                timeout_err++;
                ok = 1'b0;
                return;
            end
        end
        wr_en   = 1'b1;
        wr_vc   = vc_onehot_t'(1) << vc;
        wr_flit = f;
        credits[vc]--;
        flits_written++;
        exp_f = f;
        exp_f[VC_LSB +: V] = vc_onehot_t'(1) << vc;    // vc field names the holding vc
        exp_q[vc].push_back({cur_cls[vc], cur_dst[vc], exp_f});
        next_cycle();
        wr_en = 1'b0;
    endtask

    task automatic send_packet(output bit ok);
        vc_bin_t  vc;
        int       len;
        payload_t pay;
        vc_onehot_t tag;
        vc         = vc_bin_t'(take_bits(VC_W));
        len        = int'(take_bits(2)) + 1;   // 1 to 4 flits
        cur_cls[vc] = class_t'(take_bits(CLS_W));
        cur_dst[vc] = dest_t'(take_bits(DST_W));
        ok = 1'b1;
        for (int k = 0; k < len && ok; k++) begin
            pay = take_bits(FPAY);
            if (k == 0) begin
                pay[CLS_W-1:0]     = cur_cls[vc];  // header fields in low payload
                pay[CLS_W +: DST_W] = cur_dst[vc];
            end
            tag = vc_onehot_t'(take_bits(V));   // stale vc tag from upstream
            send_flit(vc, {k == 0, k == len - 1, tag, pay}, ok);
        end
    endtask

    task automatic drain(output bit ok);
        int n;
        rand_ready = 1'b0;
        out_ready  = 1'b1;
        ok = 1'b1;
        n  = 0;
        while (pending() != 0 || out_valid) begin
            next_cycle();
            n++;
            if (n > WAIT_MAX) begin
                $display("error: %0d flits still pending after %0d cycles", pending(), n);
                timeout_err++;
                ok = 1'b0;
                return;
            end
        end
    endtask

    task automatic finish_run();
        int total;
        int chk_err;
        chk_err = u_dut.u_chk.fail_cnt;
        total = data_err + hdr_err + credit_err + stall_err + reset_err + fair_err
                + timeout_err + chk_err;
        $write("errors: data %0d header %0d credit %0d stall %0d ",
               data_err, hdr_err, credit_err, stall_err);
        $display("reset %0d fairness %0d timeout %0d assertion %0d",
                 reset_err, fair_err, timeout_err, chk_err);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    always @(posedge clk) begin : monitor
        logic [EXP_W-1:0] e;
        vc_bin_t          w;
        if (reset_q) begin                      // registers defined after one reset edge
            if (!values_match("out_valid_o", flit_t'(0), flit_t'(out_valid))) reset_err++;
            if (!values_match("credit_o", flit_t'(0), flit_t'(credit))) reset_err++;
        end
        if (!reset) begin
            for (int i = 0; i < V; i++) begin
                if (credit[i]) begin
                    credits[i]++;
                    credits_seen++;
                    assert (credits[i] <= B) else begin
                        $display("error: vc %0d got more than %0d credits at %0t", i, B, $time);
                        credit_err++;
                    end
                end
            end
            assert (!(out_valid && flits_written == 0)) else begin
                $display("error: output valid at %0t before any flit was written", $time);
                reset_err++;
            end
            if (stall_q) begin                  // last cycle stalled, outputs held
                if (!values_match("out_valid_o", flit_t'(1), flit_t'(out_valid))) stall_err++;
                if (!values_match("out_flit_o", prev_flit, out_flit)) stall_err++;
                if (!values_match("out_vc_o", flit_t'(prev_vc), flit_t'(out_vc))) stall_err++;
                if (!values_match("out_class_o", flit_t'(prev_cls), flit_t'(out_class))) stall_err++;
                if (!values_match("out_dest_o", flit_t'(prev_dst), flit_t'(out_dest))) stall_err++;
            end
            if (!out_ready) begin
                for (int i = 0; i < V; i++) fair_on[i] = 1'b0;
            end
            if (out_valid && out_ready) begin
                w = out_vc;
                assert (exp_q[w].size() != 0) else begin
                    $display("error: flit on vc %0d at %0t with nothing expected", w, $time);
                    data_err++;
                end
                if (exp_q[w].size() != 0) begin
                    e = exp_q[w].pop_front();
                    if (!values_match("out_flit_o", e[FLIT_W-1:0], out_flit)) data_err++;
                    if (!values_match("out_flit_o.vc", flit_t'(vc_onehot_t'(1) << w),
                                      flit_t'(out_flit[VC_LSB +: V]))) data_err++;
                    if (!values_match("out_class_o", flit_t'(e[FLIT_W+DST_W +: CLS_W]),
                                      flit_t'(out_class))) hdr_err++;
                    if (!values_match("out_dest_o", flit_t'(e[FLIT_W +: DST_W]),
                                      flit_t'(out_dest))) hdr_err++;
                    for (int i = 0; i < V; i++) begin
                        if (i != int'(w) && fair_on[i]) begin
                            skip_cnt[i]++;
                            assert (skip_cnt[i] <= V) else begin
                                $display("error: vc %0d passed over %0d times at %0t",
                                         i, skip_cnt[i], $time);
                                fair_err++;
                            end
                        end
                    end
                    skip_cnt[w] = 0;
                    fair_on[w]  = (exp_q[w].size() != 0);   // still holding flits
                end
            end
        end
        reset_q   = reset;
        stall_q   = !reset && out_valid && !out_ready;
        prev_flit = out_flit;
        prev_vc   = out_vc;
        prev_cls  = out_class;
        prev_dst  = out_dest;
    end

    initial begin : main
        bit ok;
        int n;
        lfsr       = 32'hc09a;
        wr_en      = 1'b0;
        wr_vc      = '0;
        wr_flit    = '0;
        out_ready  = 1'b0;
        rand_ready = 1'b0;
        reset_q    = 1'b0;
        stall_q    = 1'b0;
        flits_written = 0;
        credits_seen  = 0;
        {data_err, hdr_err, credit_err, stall_err, reset_err, fair_err, timeout_err} = '0;
        for (int i = 0; i < V; i++) begin
            credits[i]  = B;
            skip_cnt[i] = 0;
            fair_on[i]  = 1'b0;
            cur_cls[i]  = '0;
            cur_dst[i]  = '0;
        end
        ok = 1'b1;
        n  = 0;
        @(negedge clk);
        while (reset) begin
            next_cycle();
            n++;
            if (n > WAIT_MAX) begin
                $display("error: reset still high after %0d cycles", n);
                timeout_err++;
                ok = 1'b0;
                break;
            end
        end
        if (ok) begin
            out_ready = 1'b1;
            repeat (6) next_cycle();            // idle, nothing may come out
            rand_ready = 1'b1;
            for (int p = 0; p < NUM_PKTS && ok; p++) begin
                if (take_bits(2) == 0) next_cycle();
                send_packet(ok);
            end
        end
        if (ok) drain(ok);
        if (ok) begin
            for (int i = 0; i < V; i++) begin
                assert (credits[i] == B) else begin
                    $display("[FAIL] %0t credits[%0d] exp=%0d got=%0d", $time, i, B, credits[i]);
                    credit_err++;
                end
            end
            assert (credits_seen == flits_written) else begin
                $display("[FAIL] %0t credit_o count exp=%0d got=%0d",
                         $time, flits_written, credits_seen);
                credit_err++;
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== build.f ====
logic/noc_pkg.sv
logic/vc_flit_fifo.sv
logic/head_flit_reg_buffer.sv
logic/vc_output_stage.sv
logic/noc_input_port.sv
tb/tb_clk_gen.sv
tb/noc_input_port_chk.sv
tb/noc_input_port_tb.sv
